// File: Bender.yml
package:
  name: gap_head

sources:
  - files:
      - verilog/gap_num_pkg.sv
      - verilog/gap_stream_pkg.sv
      - verilog/channel_acc.sv
      - verilog/acc_array.sv
      - verilog/pool_serializer.sv
      - verilog/class_argmax.sv
      - verilog/gap_head_top.sv
  - target: test
    files:
      - verif/gap_head_tb.sv

// File: verif/gap_head_tb.sv
`timescale 1ns/1ps

module gap_head_tb;

   import gap_num_pkg::*;
   import gap_stream_pkg::*;

   localparam int NUM_CH     = 8;
   localparam int WIDTH      = 16;
   localparam int POOL_SHIFT = 6;
   localparam int WAIT_LIMIT = 200;

   typedef logic [NUM_CH-1:0][WIDTH-1:0] pix_vec_t;

   logic           clk;
   logic           rst_n;
   branch_t        branch;
   logic           branch_start;
   logic           sample;
   logic           branch_end;
   pix_vec_t       pixels;
   logic           pool_valid;
   pooled_beat_t   pool_beat;
   logic           class_valid;
   class_result_t  class_out;

   int cyc = 0;
   int checks = 0;
   int value_errors = 0;
   int other_errors = 0;

   logic signed [WIDTH-1:0]  model_sum [NUM_CH];   // Reference sums wrap like the head
   branch_t                  model_branch;
   int                       busy_until;            // Last edge that still ignores branch_end
   pix_vec_t                 last_pooled [2];
   logic                     pending_start;

   branch_t        exp_branch_q [$];
   pix_vec_t       exp_vals_q [$];
   int             exp_start_q [$];
   pooled_beat_t   beat_q [$];
   int             beat_edge_q [$];
   class_result_t  class_q [$];
   int             class_edge_q [$];

   gap_head_top #(
      .NUM_CH     (NUM_CH),
      .WIDTH      (WIDTH),
      .POOL_SHIFT (POOL_SHIFT)
   ) dut_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .branch       (branch),
      .branch_start (branch_start),
      .sample       (sample),
      .pixels       (pixels),
      .branch_end   (branch_end),
      .pool_valid   (pool_valid),
      .pool_beat    (pool_beat),
      .class_valid  (class_valid),
      .class_out    (class_out)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   // Record outputs mid cycle with the edge that samples them
   always @(negedge clk) begin
      if (rst_n && pool_valid) begin
         beat_q.push_back(pool_beat);
         beat_edge_q.push_back(cyc + 1);
      end
      if (rst_n && class_valid) begin
         class_q.push_back(class_out);
         class_edge_q.push_back(cyc + 1);
      end
   end

   task automatic check_num(input string what, input logic [31:0] got,
                            input logic [31:0] expv);
      checks++;
      assert (got === expv) else begin
         value_errors++;
         $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, expv);
      end
   endtask

   task automatic check_val(input string what, input logic [WIDTH-1:0] got,
                            input logic [WIDTH-1:0] expv);
      checks++;
      assert (got === expv) else begin
         value_errors++;
         $display("** Error at %0t: %s is %h, expected %h", $time, what, got, expv);
      end
   endtask

   task automatic check_fields(input int rc, input int want, input string rec);
      assert (rc == want) else begin
         other_errors++;
         $display("Vectors file record %s has %0d fields where %0d were expected",
                  rec, rc, want);
      end
   endtask

   function automatic pix_vec_t random_pixels();
      pix_vec_t px;
      int c;
      for (c = 0; c < NUM_CH; c++) begin
         px[c] = WIDTH'($urandom);
      end
      return px;
   endfunction

   // Strictly greater score wins over both branches
   function automatic void model_class(output logic [ch_idx_w:0] id,
                                       output logic [WIDTH-1:0] score);
      int b;
      int c;
      id = '0;
      score = last_pooled[0][0];
      for (b = 0; b < 2; b++) begin
         for (c = 0; c < NUM_CH; c++) begin
            if ($signed(last_pooled[b][c]) > $signed(score)) begin
               id = (ch_idx_w + 1)'(b * NUM_CH + c);
               score = last_pooled[b][c];
            end
         end
      end
   endfunction

   // One clock of stimulus and the model update for the edge that samples it
   task automatic drive_cycle(input logic start, input logic smp, input logic fin,
                              input pix_vec_t px);
      int s_edge;
      int c;
      pix_vec_t pooled;
      @(posedge clk);
      #1;
      branch_start = start;
      sample = smp;
      branch_end = fin;
      pixels = px;
      s_edge = cyc + 1;
      if (fin && s_edge > busy_until) begin
         for (c = 0; c < NUM_CH; c++) begin
            pooled[c] = model_sum[c] >>> POOL_SHIFT;
         end
         last_pooled[model_branch] = pooled;
         exp_branch_q.push_back(model_branch);
         exp_vals_q.push_back(pooled);
         exp_start_q.push_back(s_edge + 2);
         busy_until = s_edge + NUM_CH;
      end
      if (start) begin
         model_branch = branch;
      end
      for (c = 0; c < NUM_CH; c++) begin
         if (start && smp) begin
            model_sum[c] = px[c];
         end else if (start) begin
            model_sum[c] = '0;
         end else if (smp) begin
            model_sum[c] = model_sum[c] + $signed(px[c]);
         end
      end
   endtask

   task automatic wait_output(input bit for_class, output bit ok);
      int n;
      n = 0;
      ok = 0;
      while (!ok && n < WAIT_LIMIT) begin
         ok = for_class ? (class_q.size() > 0) : (beat_q.size() > 0);
         if (!ok) begin
            @(posedge clk);
            n++;
         end
      end
      if (!ok) begin
         other_errors++;
         $display("Timeout at %0t: no %s arrived within %0d cycles", $time,
                  for_class ? "class result" : "pooled beat", WAIT_LIMIT);
         exp_branch_q.delete();
         exp_vals_q.delete();
         exp_start_q.delete();
      end
   endtask

   // Compares every expected stream and the class and then watches for stray output
   task automatic check_frame();
      branch_t e_br;
      pix_vec_t e_vals;
      int e_start;
      int k;
      int last_edge;
      int got_edge;
      bit ok;
      pooled_beat_t beat;
      class_result_t res;
      logic [ch_idx_w:0] e_id;
      logic [WIDTH-1:0] e_score;
      drive_cycle(0, 0, 0, pixels);
      last_edge = 0;
      while (exp_start_q.size() > 0) begin
         e_br = exp_branch_q.pop_front();
         e_vals = exp_vals_q.pop_front();
         e_start = exp_start_q.pop_front();
         for (k = 0; k < NUM_CH; k++) begin
            wait_output(0, ok);
            if (!ok) begin
               return;
            end
            beat = beat_q.pop_front();
            got_edge = beat_edge_q.pop_front();
            check_num($sformatf("edge of branch %0d beat %0d", e_br, k), got_edge, e_start + k);
            check_num("beat branch", beat.branch, e_br);
            check_num("beat channel", beat.channel, k);
            check_num("beat last", beat.last, k == NUM_CH - 1);
            check_val($sformatf("branch %0d channel %0d pooled", e_br, k), beat.value, e_vals[k]);
         end
         last_edge = e_start + NUM_CH - 1;
      end
      model_class(e_id, e_score);
      wait_output(1, ok);
      if (!ok) begin
         return;
      end
      res = class_q.pop_front();
      check_num("class edge", class_edge_q.pop_front(), last_edge + 1);
      check_num("class id", res.class_id, e_id);
      check_val("class score", res.score, e_score);
      for (k = 0; k < NUM_CH + 4; k++) begin
         @(posedge clk);
      end
      checks++;
      assert (beat_q.size() == 0 && class_q.size() == 0) else begin
         other_errors++;
         $display("Unexpected output at %0t: %0d extra beats and %0d extra class results",
                  $time, beat_q.size(), class_q.size());
         beat_q.delete();
         beat_edge_q.delete();
         class_q.delete();
         class_edge_q.delete();
      end
   endtask

   task automatic read_pixels(input int fd, output pix_vec_t px);
      int c;
      int rc;
      logic [WIDTH-1:0] v;
      for (c = 0; c < NUM_CH; c++) begin
         rc = $fscanf(fd, "%h", v);
         check_fields(rc, 1, "pixel value");
         px[c] = v;
      end
   endtask

   task automatic run_vector_file();
      int fd;
      int rc;
      int n;
      int b;
      int i;
      int with_smp;
      string tok;
      string rest;
      pix_vec_t px;
      logic [ch_idx_w:0] f_id;
      logic [WIDTH-1:0] f_score;
      logic [ch_idx_w:0] m_id;
      logic [WIDTH-1:0] m_score;
      fd = $fopen("verif/gap_head_vectors.txt", "r");
      if (fd == 0) begin
         other_errors++;
         $display("Could not open verif/gap_head_vectors.txt");
         return;
      end
      while ($fscanf(fd, "%s", tok) == 1) begin
         case (tok)
            "F": begin
               rc = $fscanf(fd, "%d", n);
               check_fields(rc, 1, tok);
               $display("Vector frame %0d at %0t", n, $time);
            end
            "B": begin
               rc = $fscanf(fd, "%d %d", b, with_smp);
               check_fields(rc, 2, tok);
               branch = branch_t'(b);
               if (with_smp != 0) begin
                  pending_start = 1'b1;              // Start shares the first sample
               end else begin
                  drive_cycle(1, 0, 0, pixels);
               end
            end
            "S": begin
               rc = $fscanf(fd, "%d", n);
               check_fields(rc, 1, tok);
               read_pixels(fd, px);
               for (i = 0; i < n; i++) begin
                  drive_cycle(pending_start && i == 0, 1, 0, px);
               end
               pending_start = 1'b0;
            end
            "E": begin
               drive_cycle(0, 0, 1, pixels);
            end
            "X": begin
               rc = $fscanf(fd, "%d", b);
               check_fields(rc, 1, tok);
               read_pixels(fd, px);
               for (i = 0; i < NUM_CH; i++) begin
                  check_val($sformatf("file pooled branch %0d channel %0d", b, i),
                            px[i], last_pooled[b][i]);
               end
            end
            "W": begin
               rc = $fscanf(fd, "%d", n);
               check_fields(rc, 1, tok);
               for (i = 0; i < n; i++) begin
                  drive_cycle(0, 0, 0, pixels);
               end
            end
            "C": begin
               rc = $fscanf(fd, "%h %h", f_id, f_score);
               check_fields(rc, 2, tok);
               model_class(m_id, m_score);
               check_num("file class id", f_id, m_id);
               check_val("file class score", f_score, m_score);
               check_frame();
            end
            default: begin
               if (tok.getc(0) != "#") begin
                  other_errors++;
                  $display("Unknown record %s in vectors file", tok);
               end
               rc = $fgets(rest, fd);
            end
         endcase
      end
      $fclose(fd);
   endtask

   task automatic run_random_frame(input int f);
      int b;
      int i;
      int gap;
      bit with_smp;
      $display("Random frame %0d at %0t", f, $time);
      for (b = 0; b < 2; b++) begin
         branch = branch_t'(b);
         with_smp = $urandom_range(1, 0);
         if (!with_smp) begin
            drive_cycle(1, 0, 0, pixels);
         end
         for (i = 0; i < (1 << POOL_SHIFT); i++) begin
            gap = $urandom_range(3, 0);
            repeat (gap) drive_cycle(0, 0, 0, random_pixels());   // Junk without sample
            drive_cycle(with_smp && i == 0, 1, 0, random_pixels());
         end
         drive_cycle(0, 0, 1, pixels);
      end
      check_frame();
   endtask

   initial begin
      int f;
      int c;
      void'($urandom(32'h954b7743));
      clk = 1'b0;
      rst_n = 1'b0;
      branch = 1'b0;
      branch_start = 1'b0;
      sample = 1'b0;
      branch_end = 1'b0;
      pixels = '0;
      for (c = 0; c < NUM_CH; c++) begin
         model_sum[c] = '0;
      end
      model_branch = 1'b0;
      busy_until = -100;
      pending_start = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      check_num("pool_valid in reset", pool_valid, 0);
      check_num("class_valid in reset", class_valid, 0);
      rst_n = 1'b1;
      run_vector_file();
      for (f = 0; f < 3; f++) begin
         run_random_frame(f);
      end
      $display("Checks: %0d, value errors: %0d, other errors: %0d",
               checks, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// File: verif/gap_head_vectors.txt
# F frame | B branch with_sample | S count v0..v7 | E branch end | W idle cycles
# X branch pooled0..pooled7 | C class_id score; counts decimal, values and ids hex
F 1
B 0 0
S 32 0003 FFFD 0100 FF9C 0400 03FF 0050 FFF9
S 32 0004 0000 0101 FFFF 0400 0001 0052 0002
E
X 0 0003 FFFE 0100 FFCD 0000 FE00 0051 FFFD
W 12
B 1 0
S 32 0001 0200 FFFE 00FF FFE0 0007 8000 0101
S 32 0001 0000 FFFE 00FF 0010 0000 0002 00FF
E
X 1 0001 0100 FFFE 00FF FFF8 0003 0001 0100
C 002 0100
F 2
B 0 1
S 64 0040 FFC0 0001 0123 FFFF 0000 0080 0020
E
X 0 0040 FFC0 0001 0123 FFFF 0000 0080 0020
B 1 1
S 64 0030 0200 0010 0150 FF00 0123 0002 0150
E
X 1 0030 FE00 0010 0150 FF00 0123 0002 0150
W 2
E
C 00B 0150
F 3
B 0 0
S 64 FFFB FFFD FF9C FFFE FFFE FFF7 FFD8 FFFD
E
X 0 FFFB FFFD FF9C FFFE FFFE FFF7 FFD8 FFFD
B 1 0
S 64 FFFE FFF9 FED4 FFFC FFFE FFC0 FFF5 FFF8
E
X 1 FFFE FFF9 FED4 FFFC FFFE FFC0 FFF5 FFF8
C 003 FFFE

// File: verilog.f
verilog/gap_num_pkg.sv
verilog/gap_stream_pkg.sv
verilog/channel_acc.sv
verilog/acc_array.sv
verilog/pool_serializer.sv
verilog/class_argmax.sv
verilog/gap_head_top.sv
verif/gap_head_tb.sv

// File: verilog/acc_array.sv
`timescale 1ns/1ps

module acc_array #(
   parameter int NUM_CH     = 8,
   parameter int WIDTH      = gap_num_pkg::pixel_w,
   parameter int POOL_SHIFT = gap_num_pkg::pool_shift_default
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  gap_num_pkg::branch_t          branch,
   input  logic                          branch_start,
   input  logic                          sample,
   input  logic                          branch_end,
   input  logic [NUM_CH-1:0][WIDTH-1:0]  pixels,
   input  logic                          ser_busy,
   output logic                          snap_valid,
   output gap_num_pkg::branch_t          snap_branch,
   output logic [NUM_CH-1:0][WIDTH-1:0]  snap_values
);

   import gap_num_pkg::*;

   branch_t                       cur_branch;
   logic [NUM_CH-1:0][WIDTH-1:0]  sums;
   logic [NUM_CH-1:0][WIDTH-1:0]  pooled;
   logic                          accept;

   genvar i;
   generate
      for (i = 0; i < NUM_CH; i++) begin : g_ch
         channel_acc #(
            .WIDTH (WIDTH)
         ) u_acc (
            .clk    (clk),
            .rst_n  (rst_n),
            .clear  (branch_start),
            .sample (sample),
            .pixel  (pixels[i]),
            .acc    (sums[i])
         );

         // Average over 2**POOL_SHIFT positions, truncating
         assign pooled[i] = $signed(sums[i]) >>> POOL_SHIFT;
      end
   endgenerate

   // A snapshot still waiting for the serializer also blocks
   assign accept = branch_end && !ser_busy && !snap_valid;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cur_branch <= 1'b0;
         snap_valid <= 1'b0;
      end else begin
         if (branch_start) begin
            cur_branch <= branch;
         end
         snap_valid <= accept;
      end
   end

   // Sums as they stand before this edge, a sample here goes to the next branch end
   always_ff @(posedge clk) begin
      if (accept) begin
         snap_values <= pooled;
         snap_branch <= cur_branch;
      end
   end

endmodule

// File: verilog/channel_acc.sv
`timescale 1ns/1ps

module channel_acc #(
   parameter int WIDTH = gap_num_pkg::pixel_w
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    clear,
   input  logic                    sample,
   input  logic signed [WIDTH-1:0] pixel,
   output logic signed [WIDTH-1:0] acc
);

   // Running sum of one channel, wraps in WIDTH bits
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         acc <= '0;
      end else if (clear && sample) begin
         acc <= pixel;                       // First sample of a new branch
      end else if (clear) begin
         acc <= '0;
      end else if (sample) begin
         acc <= acc + pixel;
      end
   end

endmodule

// File: verilog/class_argmax.sv
`timescale 1ns/1ps

module class_argmax #(
   parameter int NUM_CH = 8
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          pool_valid,
   input  gap_stream_pkg::pooled_beat_t  pool_beat,
   output logic                          class_valid,
   output gap_stream_pkg::class_result_t class_out
);

   import gap_num_pkg::*;
   import gap_stream_pkg::*;

   localparam logic [ch_idx_w:0] branch1_base = (ch_idx_w + 1)'(NUM_CH);

   class_result_t      best;
   logic [ch_idx_w:0]  cand_id;
   logic               restart;

   assign cand_id = (pool_beat.branch ? branch1_base : '0) + {1'b0, pool_beat.channel};
   assign restart = !pool_beat.branch && (pool_beat.channel == '0);

   // Strictly greater, so ties keep the lower class id
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         best        <= '0;
         class_valid <= 1'b0;
      end else begin
         class_valid <= pool_valid && pool_beat.last && pool_beat.branch;
         if (pool_valid) begin
            if (restart || (pool_beat.value > best.score)) begin
               best.class_id <= cand_id;
               best.score    <= pool_beat.value;
            end
         end
      end
   end

   assign class_out = best;                  // Already includes the final beat

endmodule

// File: verilog/gap_head_top.sv
`timescale 1ns/1ps

module gap_head_top #(
   parameter int NUM_CH     = 8,
   parameter int WIDTH      = gap_num_pkg::pixel_w,
   parameter int POOL_SHIFT = gap_num_pkg::pool_shift_default
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  gap_num_pkg::branch_t          branch,
   input  logic                          branch_start,
   input  logic                          sample,
   input  logic [NUM_CH-1:0][WIDTH-1:0]  pixels,
   input  logic                          branch_end,
   output logic                          pool_valid,
   output gap_stream_pkg::pooled_beat_t  pool_beat,
   output logic                          class_valid,
   output gap_stream_pkg::class_result_t class_out
);

   import gap_num_pkg::*;

   logic                          snap_valid;
   branch_t                       snap_branch;
   logic [NUM_CH-1:0][WIDTH-1:0]  snap_values;
   logic                          ser_busy;

   acc_array #(
      .NUM_CH     (NUM_CH),
      .WIDTH      (WIDTH),
      .POOL_SHIFT (POOL_SHIFT)
   ) u_acc_array (
      .clk          (clk),
      .rst_n        (rst_n),
      .branch       (branch),
      .branch_start (branch_start),
      .sample       (sample),
      .branch_end   (branch_end),
      .pixels       (pixels),
      .ser_busy     (ser_busy),
      .snap_valid   (snap_valid),
      .snap_branch  (snap_branch),
      .snap_values  (snap_values)
   );

   pool_serializer #(
      .NUM_CH (NUM_CH),
      .WIDTH  (WIDTH)
   ) u_pool_serializer (
      .clk         (clk),
      .rst_n       (rst_n),
      .snap_valid  (snap_valid),
      .snap_branch (snap_branch),
      .snap_values (snap_values),
      .ser_busy    (ser_busy),
      .pool_valid  (pool_valid),
      .pool_beat   (pool_beat)
   );

   class_argmax #(
      .NUM_CH (NUM_CH)
   ) u_class_argmax (
      .clk         (clk),
      .rst_n       (rst_n),
      .pool_valid  (pool_valid),
      .pool_beat   (pool_beat),
      .class_valid (class_valid),
      .class_out   (class_out)
   );

endmodule

// File: verilog/gap_num_pkg.sv
package gap_num_pkg;

   // Channel values are signed two's complement, sums wrap at this width
   localparam int pixel_w = 16;

   // Up to 512 channels per branch
   localparam int ch_idx_w = 9;

   // log2 of the spatial positions per branch, 64 positions
   localparam int pool_shift_default = 6;

   // The last conv layer delivers its channels in two branches
   typedef logic branch_t;

endpackage

// File: verilog/gap_stream_pkg.sv
package gap_stream_pkg;

   import gap_num_pkg::*;

   // One pooled channel value on the output stream
   typedef struct packed {
      branch_t                    branch;
      logic [ch_idx_w-1:0]        channel;
      logic                       last;     // Final channel of the branch
      logic signed [pixel_w-1:0]  value;
   } pooled_beat_t;

   // Winning class over both branches
   // class_id is branch * NUM_CH + channel
   typedef struct packed {
      logic [ch_idx_w:0]          class_id;
      logic signed [pixel_w-1:0]  score;
   } class_result_t;

endpackage

// File: verilog/pool_serializer.sv
`timescale 1ns/1ps

module pool_serializer #(
   parameter int NUM_CH = 8,
   parameter int WIDTH  = gap_num_pkg::pixel_w
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          snap_valid,
   input  gap_num_pkg::branch_t          snap_branch,
   input  logic [NUM_CH-1:0][WIDTH-1:0]  snap_values,
   output logic                          ser_busy,
   output logic                          pool_valid,
   output gap_stream_pkg::pooled_beat_t  pool_beat
);

   import gap_num_pkg::*;

   localparam logic [ch_idx_w-1:0] last_ch = ch_idx_w'(NUM_CH - 1);

   logic [NUM_CH-1:0][WIDTH-1:0]  bank;
   logic [ch_idx_w-1:0]           cnt;
   logic                          busy;

   assign ser_busy = busy;

   // Channel 0 goes out on the load edge, the counter walks the rest
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy       <= 1'b0;
         cnt        <= '0;
         pool_valid <= 1'b0;
      end else begin
         pool_valid <= snap_valid || busy;
         if (snap_valid) begin
            cnt  <= ch_idx_w'(1);
            busy <= (NUM_CH > 1);
         end else if (busy) begin
            cnt <= cnt + 1'b1;
            if (cnt == last_ch) begin
               busy <= 1'b0;                 // Last beat leaves on this edge
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (snap_valid) begin
         bank              <= snap_values;    // Frees acc_array for the next branch
         pool_beat.branch  <= snap_branch;
         pool_beat.channel <= '0;
         pool_beat.last    <= (NUM_CH == 1);
         pool_beat.value   <= snap_values[0];
      end else if (busy) begin
         pool_beat.channel <= cnt;
         pool_beat.last    <= (cnt == last_ch);
         pool_beat.value   <= bank[cnt];
      end
   end

endmodule
